// ==== logic/issue_pkg.sv ====
`default_nettype none

package issue_pkg;

  localparam int DATA_W = 32;
  localparam int TAG_W  = 5;
  localparam int IMM_W  = 12;

  // Selects the station a micro-op is routed to
  typedef enum logic {
    FU_ALU = 1'b0,
    FU_LS  = 1'b1
  } fu_kind_t;

  typedef enum logic [3:0] {
    OP_ADD  = 4'd0,
    OP_SUB  = 4'd1,
    OP_AND  = 4'd2,
    OP_ORR  = 4'd3,
    OP_EOR  = 4'd4,
    OP_ADDS = 4'd5,
    OP_SUBS = 4'd6,
    OP_LDUR = 4'd7,
    OP_STUR = 4'd8
  } fu_op_t;

  typedef struct packed {
    logic n;
    logic z;
    logic c;
    logic v;
  } nzcv_t;

  // Either a value (valid) or the ROB tag still awaited
  typedef struct packed {
    logic              valid;
    logic [TAG_W-1:0]  tag;
    logic [DATA_W-1:0] value;
  } operand_t;

  typedef struct packed {
    fu_kind_t         kind;
    fu_op_t           op;
    operand_t         a;
    operand_t         b;
    logic [IMM_W-1:0] imm;
    logic [TAG_W-1:0] dst;
  } dispatch_t;

  typedef struct packed {
    fu_op_t            op;
    logic [DATA_W-1:0] val_a;
    logic [DATA_W-1:0] val_b;
    logic [IMM_W-1:0]  imm;
    logic [TAG_W-1:0]  dst;
  } issue_t;

  typedef struct packed {
    logic [TAG_W-1:0]  tag;
    logic [DATA_W-1:0] value;
    logic              set_nzcv;
    nzcv_t             nzcv;
  } cdb_t;

endpackage

`default_nettype wire

// ==== logic/rs_station.sv ====
`timescale 1ns/1ps
`default_nettype none

module rs_station
  import issue_pkg::*;
#(
  parameter int       RS_DEPTH = 4,
  parameter fu_kind_t FU_KIND  = FU_ALU
) (
  input  wire logic      in_clk,
  input  wire logic      in_rst_n,
  input  wire logic      dispatch_valid,
  input  wire dispatch_t dispatch,
  input  wire logic      cdb_valid,
  input  wire cdb_t      cdb,
  input  wire logic      fu_ready,
  output logic           full,
  output logic           issue_start,
  output issue_t         issue
);

  localparam int IDX_W = (RS_DEPTH > 1) ? $clog2(RS_DEPTH) : 1;

  // Age counts the valid entries that are older than this one
  typedef struct packed {
    fu_op_t           op;
    operand_t         a;
    operand_t         b;
    logic [IMM_W-1:0] imm;
    logic [TAG_W-1:0] dst;
    logic [IDX_W-1:0] age;
  } entry_t;

  logic [RS_DEPTH-1:0] busy;
  entry_t              ent [RS_DEPTH];

  logic [RS_DEPTH-1:0] ready_vec;
  logic                found;
  logic [IDX_W-1:0]    sel;
  logic [IDX_W-1:0]    best_age;
  logic [IDX_W-1:0]    free_idx;
  logic [IDX_W-1:0]    stay_cnt;
  logic                insert;

  // Picks up a value broadcast on the CDB for an operand still waiting on it
  function automatic operand_t capture(operand_t op, logic bc_valid, cdb_t bc);
    operand_t res;
    res = op;
    if (!op.valid && bc_valid && (bc.tag == op.tag)) begin
      res.valid = 1'b1;
      res.value = bc.value;
    end
    return res;
  endfunction

  assign full   = &busy;
  assign insert = dispatch_valid && (dispatch.kind == FU_KIND) && !full;

  always_comb begin
    for (int i = 0; i < RS_DEPTH; i++) begin
      ready_vec[i] = busy[i] & ent[i].a.valid & ent[i].b.valid;
    end
  end

  // Oldest ready entry
  always_comb begin
    found    = 1'b0;
    sel      = '0;
    best_age = '0;
    for (int i = 0; i < RS_DEPTH; i++) begin
      if (ready_vec[i] && (!found || (ent[i].age < best_age))) begin
        found    = 1'b1;
        sel      = IDX_W'(i);
        best_age = ent[i].age;
      end
    end
  end

  // Lowest free slot, only meaningful while not full
  always_comb begin
    free_idx = '0;
    for (int i = RS_DEPTH - 1; i >= 0; i--) begin
      if (!busy[i]) begin
        free_idx = IDX_W'(i);
      end
    end
  end

  assign issue_start = fu_ready & found;

  always_comb begin
    issue.op    = ent[sel].op;
    issue.val_a = ent[sel].a.value;
    issue.val_b = ent[sel].b.value;
    issue.imm   = ent[sel].imm;
    issue.dst   = ent[sel].dst;
  end

  // Entries that survive this cycle are all older than the new one
  always_comb begin
    stay_cnt = '0;
    for (int i = 0; i < RS_DEPTH; i++) begin
      if (busy[i] && !(issue_start && (sel == IDX_W'(i)))) begin
        stay_cnt = stay_cnt + IDX_W'(1);
      end
    end
  end

  always_ff @(posedge in_clk or negedge in_rst_n) begin
    if (!in_rst_n) begin
      busy <= '0;
    end else begin
      if (issue_start) begin
        busy[sel] <= 1'b0;
      end
      if (insert) begin
        busy[free_idx] <= 1'b1;
      end
    end
  end

  always_ff @(posedge in_clk) begin
    for (int i = 0; i < RS_DEPTH; i++) begin
      // CDB wakeup
      ent[i].a <= capture(ent[i].a, cdb_valid, cdb);
      ent[i].b <= capture(ent[i].b, cdb_valid, cdb);
      if (issue_start && busy[i] && (ent[i].age > best_age)) begin
        ent[i].age <= ent[i].age - IDX_W'(1);
      end
    end
    if (insert) begin
      ent[free_idx].op  <= dispatch.op;
      ent[free_idx].a   <= capture(dispatch.a, cdb_valid, cdb);
      ent[free_idx].b   <= capture(dispatch.b, cdb_valid, cdb);
      ent[free_idx].imm <= dispatch.imm;
      ent[free_idx].dst <= dispatch.dst;
      ent[free_idx].age <= stay_cnt;
    end
  end

  // Producer has to respect the full flag, dispatch never stalls
  a_no_dispatch_when_full: assert property (@(posedge in_clk) disable iff (!in_rst_n)
    (dispatch_valid && (dispatch.kind == FU_KIND)) |-> !full);

  // Unit has to hold its slot for at least the cycle after a start
  a_issue_into_free_unit: assert property (@(posedge in_clk) disable iff (!in_rst_n)
    issue_start |-> fu_ready ##1 !fu_ready);

endmodule

`default_nettype wire

// ==== logic/alu_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu_unit
  import issue_pkg::*;
(
  input  wire logic   in_clk,
  input  wire logic   in_rst_n,
  input  wire logic   start,
  input  wire issue_t issue,
  input  wire logic   result_taken,
  output logic        fu_ready,
  output logic        result_valid,
  output cdb_t        result
);

  logic [DATA_W:0]   add_full;
  logic [DATA_W:0]   sub_full;
  logic              add_ovf;
  logic              sub_ovf;
  cdb_t              next_result;

  // Extra bit holds the unsigned carry-out
  assign add_full = {1'b0, issue.val_a} + {1'b0, issue.val_b};
  assign sub_full = {1'b0, issue.val_a} + {1'b0, ~issue.val_b} + {{DATA_W{1'b0}}, 1'b1};

  assign add_ovf = (issue.val_a[DATA_W-1] == issue.val_b[DATA_W-1]) &&
                   (add_full[DATA_W-1] != issue.val_a[DATA_W-1]);
  assign sub_ovf = (issue.val_a[DATA_W-1] != issue.val_b[DATA_W-1]) &&
                   (sub_full[DATA_W-1] != issue.val_a[DATA_W-1]);

  always_comb begin
    next_result.tag      = issue.dst;
    next_result.set_nzcv = 1'b0;
    next_result.nzcv     = '0;
    case (issue.op)
      OP_ADD, OP_ADDS: next_result.value = add_full[DATA_W-1:0];
      OP_SUB, OP_SUBS: next_result.value = sub_full[DATA_W-1:0];
      OP_AND:          next_result.value = issue.val_a & issue.val_b;
      OP_ORR:          next_result.value = issue.val_a | issue.val_b;
      OP_EOR:          next_result.value = issue.val_a ^ issue.val_b;
      default:         next_result.value = '0;
    endcase
    // Flag-setting forms only
    if ((issue.op == OP_ADDS) || (issue.op == OP_SUBS)) begin
      next_result.set_nzcv = 1'b1;
      next_result.nzcv.n   = next_result.value[DATA_W-1];
      next_result.nzcv.z   = (next_result.value == '0);
      next_result.nzcv.c   = (issue.op == OP_ADDS) ? add_full[DATA_W] : sub_full[DATA_W];
      next_result.nzcv.v   = (issue.op == OP_ADDS) ? add_ovf : sub_ovf;
    end
  end

  // One-deep result slot
  always_ff @(posedge in_clk or negedge in_rst_n) begin
    if (!in_rst_n) begin
      result_valid <= 1'b0;
    end else if (start) begin
      result_valid <= 1'b1;
    end else if (result_taken) begin
      result_valid <= 1'b0;
    end
  end

  always_ff @(posedge in_clk) begin
    if (start) begin
      result <= next_result;
    end
  end

  assign fu_ready = ~result_valid;

  a_no_start_when_held: assert property (@(posedge in_clk) disable iff (!in_rst_n)
    start |-> !result_valid);

endmodule

`default_nettype wire

// ==== logic/ls_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module ls_unit
  import issue_pkg::*;
#(
  parameter int MEM_WORDS = 64
) (
  input  wire logic   in_clk,
  input  wire logic   in_rst_n,
  input  wire logic   start,
  input  wire issue_t issue,
  input  wire logic   result_taken,
  output logic        fu_ready,
  output logic        result_valid,
  output cdb_t        result
);

  localparam int ADDR_W = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;

  logic [DATA_W-1:0]    mem [MEM_WORDS];
  // Words never stored to read as zero
  logic [MEM_WORDS-1:0] written;
  logic [DATA_W-1:0]    eff_addr;
  logic [ADDR_W-1:0]    word_idx;
  logic [DATA_W-1:0]    load_data;

  // Offset is sign-extended before the add
  assign eff_addr  = issue.val_a + {{(DATA_W-IMM_W){issue.imm[IMM_W-1]}}, issue.imm};
  assign word_idx  = ADDR_W'(eff_addr % MEM_WORDS);
  assign load_data = written[word_idx] ? mem[word_idx] : '0;

  always_ff @(posedge in_clk or negedge in_rst_n) begin
    if (!in_rst_n) begin
      result_valid <= 1'b0;
      written      <= '0;
    end else begin
      if (start) begin
        result_valid <= 1'b1;
      end else if (result_taken) begin
        result_valid <= 1'b0;
      end
      if (start && (issue.op == OP_STUR)) begin
        written[word_idx] <= 1'b1;
      end
    end
  end

  always_ff @(posedge in_clk) begin
    if (start) begin
      if (issue.op == OP_STUR) begin
        mem[word_idx] <= issue.val_b;
      end
      result.tag      <= issue.dst;
      // Stores still complete their tag, with value zero
      result.value    <= (issue.op == OP_LDUR) ? load_data : '0;
      result.set_nzcv <= 1'b0;
      result.nzcv     <= '0;
    end
  end

  assign fu_ready = ~result_valid;

  // Routing by kind in the station must keep ALU ops out
  a_only_mem_ops: assert property (@(posedge in_clk) disable iff (!in_rst_n)
    start |-> (issue.op inside {OP_LDUR, OP_STUR}));

endmodule

`default_nettype wire

// ==== logic/cdb_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module cdb_arbiter
  import issue_pkg::*;
(
  input  wire logic in_clk,
  input  wire logic in_rst_n,
  input  wire logic alu_valid,
  input  wire cdb_t alu_result,
  input  wire logic ls_valid,
  input  wire cdb_t ls_result,
  output logic      alu_taken,
  output logic      ls_taken,
  output logic      cdb_valid,
  output cdb_t      cdb
);

  // ALU wins when both slots are full
  assign alu_taken = alu_valid;
  assign ls_taken  = ls_valid & ~alu_valid;

  always_ff @(posedge in_clk or negedge in_rst_n) begin
    if (!in_rst_n) begin
      cdb_valid <= 1'b0;
    end else begin
      cdb_valid <= alu_taken | ls_taken;
    end
  end

  always_ff @(posedge in_clk) begin
    if (alu_taken) begin
      cdb <= alu_result;
    end else if (ls_taken) begin
      cdb <= ls_result;
    end
  end

  // A grant to the ALU excludes the LS unit and empties the ALU slot
  a_one_grant: assert property (@(posedge in_clk) disable iff (!in_rst_n)
    alu_taken |-> !ls_taken ##1 !alu_valid);

  // A losing LS result must wait unchanged in its slot
  a_ls_held_while_blocked: assert property (@(posedge in_clk) disable iff (!in_rst_n)
    (ls_valid && !ls_taken) |=> (ls_valid && $stable(ls_result)));

endmodule

`default_nettype wire

// ==== logic/issue_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module issue_core
  import issue_pkg::*;
#(
  parameter int ALU_RS_DEPTH = 4,
  parameter int LS_RS_DEPTH  = 4,
  parameter int MEM_WORDS    = 64
) (
  input  wire logic      in_clk,
  input  wire logic      in_rst_n,
  input  wire logic      dispatch_valid,
  input  wire dispatch_t dispatch,
  output logic           alu_rs_full,
  output logic           ls_rs_full,
  output logic           cdb_valid,
  output cdb_t           cdb
);

  logic   alu_start;
  logic   ls_start;
  issue_t alu_issue;
  issue_t ls_issue;
  logic   alu_ready;
  logic   ls_ready;
  logic   alu_res_valid;
  logic   ls_res_valid;
  cdb_t   alu_res;
  cdb_t   ls_res;
  logic   alu_taken;
  logic   ls_taken;

  // Both stations see every dispatch and every broadcast
  rs_station #(.RS_DEPTH(ALU_RS_DEPTH), .FU_KIND(FU_ALU)) alu_rs (
    .in_clk, .in_rst_n, .dispatch_valid, .dispatch, .cdb_valid, .cdb,
    .fu_ready(alu_ready), .full(alu_rs_full), .issue_start(alu_start), .issue(alu_issue)
  );

  rs_station #(.RS_DEPTH(LS_RS_DEPTH), .FU_KIND(FU_LS)) ls_rs (
    .in_clk, .in_rst_n, .dispatch_valid, .dispatch, .cdb_valid, .cdb,
    .fu_ready(ls_ready), .full(ls_rs_full), .issue_start(ls_start), .issue(ls_issue)
  );

  alu_unit u_alu (
    .in_clk, .in_rst_n, .start(alu_start), .issue(alu_issue), .result_taken(alu_taken),
    .fu_ready(alu_ready), .result_valid(alu_res_valid), .result(alu_res)
  );

  ls_unit #(.MEM_WORDS(MEM_WORDS)) u_ls (
    .in_clk, .in_rst_n, .start(ls_start), .issue(ls_issue), .result_taken(ls_taken),
    .fu_ready(ls_ready), .result_valid(ls_res_valid), .result(ls_res)
  );

  cdb_arbiter u_arb (
    .in_clk, .in_rst_n,
    .alu_valid(alu_res_valid), .alu_result(alu_res),
    .ls_valid(ls_res_valid), .ls_result(ls_res),
    .alu_taken, .ls_taken, .cdb_valid, .cdb
  );

endmodule

`default_nettype wire

// ==== tb/tb_clock.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
  parameter real PERIOD_NS  = 8.0,
  parameter int  RST_CYCLES = 10
) (
  output logic in_clk,
  output logic in_rst_n
);

  initial begin
    in_clk = 1'b0;
    forever #(PERIOD_NS / 2.0) in_clk = ~in_clk;
  end

  // Reset held low for a fixed number of rising edges
  initial begin
    in_rst_n = 1'b0;
    repeat (RST_CYCLES) @(posedge in_clk);
    in_rst_n <= 1'b1;
  end

endmodule

`default_nettype wire

// ==== tb/issue_core_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module issue_core_tb import issue_pkg::*; ();

  localparam int MEM_WORDS = 64;
  localparam int NTAGS     = 2 ** TAG_W;
  localparam int TIMEOUT   = 300;

  logic      in_clk;
  logic      in_rst_n;
  logic      dispatch_valid;
  dispatch_t dispatch;
  logic      alu_rs_full;
  logic      ls_rs_full;
  logic      cdb_valid;
  cdb_t      cdb;

  // Scoreboard
  logic [DATA_W-1:0] exp_val  [NTAGS];
  logic              exp_set  [NTAGS];
  nzcv_t             exp_nzcv [NTAGS];
  logic              lat_chk  [NTAGS];
  int                disp_cyc [NTAGS];
  int                sent_cnt [NTAGS];
  int                seen_cnt [NTAGS];
  logic [DATA_W-1:0] mem_model [MEM_WORDS];
  int                cyc = 0;
  int                n_disp = 0;
  int                n_bcast = 0;
  int                seed = 32'h2050_e0a1;
  logic [TAG_W-1:0]  next_tag = '0;

  tb_clock #(.PERIOD_NS(8.0), .RST_CYCLES(10)) clk_gen (.in_clk, .in_rst_n);

  issue_core #(.MEM_WORDS(MEM_WORDS)) uut (
    .in_clk, .in_rst_n, .dispatch_valid, .dispatch,
    .alu_rs_full, .ls_rs_full, .cdb_valid, .cdb
  );

  always @(posedge in_clk) begin
    cyc <= cyc + 1;
    if (in_rst_n && cdb_valid) begin
      seen_cnt[cdb.tag] <= seen_cnt[cdb.tag] + 1;
      n_bcast           <= n_bcast + 1;
    end
  end

  a_tag_pending: assert property (@(posedge in_clk) disable iff (!in_rst_n)
    cdb_valid |-> (sent_cnt[cdb.tag] > seen_cnt[cdb.tag]))
  else begin
    $display("Broadcast of tag %0d which is not pending", $sampled(cdb.tag));
    $display("ERRORS FOUND");
    $fatal(1);
  end

  a_value: assert property (@(posedge in_clk) disable iff (!in_rst_n)
    cdb_valid |-> (cdb.value == exp_val[cdb.tag]))
  else begin
    $display("** Error: cdb.value = %h, expected %h (tag %h)", $sampled(cdb.value),
             exp_val[$sampled(cdb.tag)], $sampled(cdb.tag));
    $display("ERRORS FOUND");
    $fatal(1);
  end

  a_flags: assert property (@(posedge in_clk) disable iff (!in_rst_n)
    cdb_valid |-> (cdb.set_nzcv == exp_set[cdb.tag]) && (cdb.nzcv == exp_nzcv[cdb.tag]))
  else begin
    $display("** Error: cdb.set_nzcv/cdb.nzcv = %h/%h, expected %h/%h (tag %h)",
             $sampled(cdb.set_nzcv), $sampled(cdb.nzcv), exp_set[$sampled(cdb.tag)],
             exp_nzcv[$sampled(cdb.tag)], $sampled(cdb.tag));
    $display("ERRORS FOUND");
    $fatal(1);
  end

  // Counter is sampled at the edge that closes the broadcast cycle
  a_latency: assert property (@(posedge in_clk) disable iff (!in_rst_n)
    (cdb_valid && lat_chk[cdb.tag]) |-> (cyc == disp_cyc[cdb.tag] + 4))
  else begin
    $display("Tag %0d was not broadcast 3 cycles after its dispatch", $sampled(cdb.tag));
    $display("ERRORS FOUND");
    $fatal(1);
  end

  function automatic logic [DATA_W-1:0] alu_value(fu_op_t op, logic [DATA_W-1:0] a,
                                                   logic [DATA_W-1:0] b);
    case (op)
      OP_ADD, OP_ADDS: return a + b;
      OP_SUB, OP_SUBS: return a - b;
      OP_AND:          return a & b;
      OP_ORR:          return a | b;
      OP_EOR:          return a ^ b;
      default:         return '0;
    endcase
  endfunction

  function automatic nzcv_t alu_flags(fu_op_t op, logic [DATA_W-1:0] a, logic [DATA_W-1:0] b);
    nzcv_t             f;
    logic [DATA_W-1:0] r;
    logic [DATA_W:0]   w;
    r = alu_value(op, a, b);
    // Overflow shows as differing top bits of the sign-extended result
    if (op == OP_ADDS) begin
      w   = {a[DATA_W-1], a} + {b[DATA_W-1], b};
      f.c = (r < a);
    end else begin
      w   = {a[DATA_W-1], a} - {b[DATA_W-1], b};
      // No borrow means carry set
      f.c = (a >= b);
    end
    f.n = r[DATA_W-1];
    f.z = (r == '0);
    f.v = (w[DATA_W] != w[DATA_W-1]);
    return f;
  endfunction

  function automatic operand_t ready_op(logic [DATA_W-1:0] v);
    operand_t o;
    o.valid = 1'b1;
    o.tag   = '0;
    o.value = v;
    return o;
  endfunction

  function automatic operand_t wait_op(logic [TAG_W-1:0] t);
    operand_t o;
    o.valid = 1'b0;
    o.tag   = t;
    o.value = '0;
    return o;
  endfunction

  function automatic logic [DATA_W-1:0] opnd_value(operand_t o);
    return o.valid ? o.value : exp_val[o.tag];
  endfunction

  function automatic dispatch_t mk_alu(fu_op_t op, operand_t a, operand_t b,
                                       logic [TAG_W-1:0] dst);
    dispatch_t d;
    d.kind = FU_ALU;
    d.op   = op;
    d.a    = a;
    d.b    = b;
    d.imm  = '0;
    d.dst  = dst;
    return d;
  endfunction

  function automatic dispatch_t mk_ls(fu_op_t op, operand_t base, operand_t data,
                                      logic [IMM_W-1:0] imm, logic [TAG_W-1:0] dst);
    dispatch_t d;
    d.kind = FU_LS;
    d.op   = op;
    d.a    = base;
    d.b    = data;
    d.imm  = imm;
    d.dst  = dst;
    return d;
  endfunction

  task automatic stop_on_timeout(string what);
    $display("Timeout while waiting for %s", what);
    $display("ERRORS FOUND");
    $fatal(1);
  endtask

  task automatic alloc(output logic [TAG_W-1:0] t);
    t        = next_tag;
    next_tag = next_tag + 1'b1;
  endtask

  // Expected broadcast of one micro-op, memory model kept in program order
  task automatic record_expect(dispatch_t d);
    logic [DATA_W-1:0] a;
    logic [DATA_W-1:0] b;
    logic [DATA_W-1:0] addr;
    int                idx;
    a = opnd_value(d.a);
    b = opnd_value(d.b);
    if (d.kind == FU_ALU) begin
      exp_val[d.dst]  = alu_value(d.op, a, b);
      exp_set[d.dst]  = (d.op == OP_ADDS) || (d.op == OP_SUBS);
      exp_nzcv[d.dst] = exp_set[d.dst] ? alu_flags(d.op, a, b) : '0;
    end else begin
      addr = a + {{(DATA_W-IMM_W){d.imm[IMM_W-1]}}, d.imm};
      idx  = int'(addr % MEM_WORDS);
      if (d.op == OP_STUR) begin
        mem_model[idx] = b;
        exp_val[d.dst] = '0;
      end else begin
        exp_val[d.dst] = mem_model[idx];
      end
      exp_set[d.dst]  = 1'b0;
      exp_nzcv[d.dst] = '0;
    end
  endtask

  // Leaves dispatch_valid high; idle or the next send ends the strobe
  task automatic send(dispatch_t d, logic chk);
    int t;
    t = 0;
    @(negedge in_clk);
    while ((d.kind == FU_ALU) ? alu_rs_full : ls_rs_full) begin
      if (t >= TIMEOUT) stop_on_timeout("a free station entry");
      t++;
      @(negedge in_clk);
    end
    record_expect(d);
    sent_cnt[d.dst] = sent_cnt[d.dst] + 1;
    lat_chk[d.dst]  = chk;
    n_disp          = n_disp + 1;
    @(posedge in_clk);
    disp_cyc[d.dst] = cyc;
    dispatch_valid <= 1'b1;
    dispatch       <= d;
  endtask

  task automatic idle();
    @(posedge in_clk);
    dispatch_valid <= 1'b0;
  endtask

  task automatic wait_tag(logic [TAG_W-1:0] tag);
    int t;
    t = 0;
    @(negedge in_clk);
    while (seen_cnt[tag] != sent_cnt[tag]) begin
      if (t >= TIMEOUT) stop_on_timeout("a single broadcast");
      t++;
      @(negedge in_clk);
    end
  endtask

  task automatic wait_drain();
    int t;
    t = 0;
    @(negedge in_clk);
    while (n_bcast != n_disp) begin
      if (t >= TIMEOUT) stop_on_timeout("all pending tags to broadcast");
      t++;
      @(negedge in_clk);
    end
  endtask

  // Full flag of the LS station when ls is set, else of the ALU station
  task automatic check_full(logic ls);
    logic flag;
    @(negedge in_clk);
    flag = ls ? ls_rs_full : alu_rs_full;
    assert (flag) else begin
      $display("** Error: %s = %h, expected %h", ls ? "ls_rs_full" : "alu_rs_full",
               flag, 1'b1);
      $display("ERRORS FOUND");
      $fatal(1);
    end
  endtask

  initial begin
    logic [TAG_W-1:0]  p1, p2, p3, p4, late, x, s, l;
    logic [DATA_W-1:0] r1, r2;
    logic [IMM_W-1:0]  imm;
    int                t;
    dispatch_valid = 1'b0;
    dispatch       = '0;
    for (int i = 0; i < NTAGS; i++) begin
      sent_cnt[i] = 0;
      seen_cnt[i] = 0;
      lat_chk[i]  = 1'b0;
      exp_val[i]  = '0;
    end
    for (int i = 0; i < MEM_WORDS; i++) mem_model[i] = '0;

    t = 0;
    while (in_rst_n !== 1'b1) begin
      if (t >= TIMEOUT) stop_on_timeout("reset release");
      t++;
      @(posedge in_clk);
    end

    // Independent ALU ops, uncontended latency
    repeat (6) begin
      alloc(p1);
      r1 = $random(seed);
      r2 = $random(seed);
      send(mk_alu(fu_op_t'($unsigned($random(seed)) % 6), ready_op(r1), ready_op(r2), p1), 1'b1);
      idle();
    end
    wait_drain();

    // Chain, second op dispatched in the producer's broadcast cycle
    alloc(p1);
    alloc(p2);
    alloc(p3);
    alloc(p4);
    send(mk_alu(OP_ADD, ready_op($random(seed)), ready_op($random(seed)), p1), 1'b0);
    idle();
    idle();
    send(mk_alu(OP_SUB, wait_op(p1), ready_op($random(seed)), p2), 1'b0);
    send(mk_alu(OP_AND, wait_op(p2), ready_op(exp_val[p1]), p3), 1'b0);
    send(mk_alu(OP_ORR, wait_op(p3), wait_op(p2), p4), 1'b0);
    idle();
    wait_drain();

    // Flag corner cases
    alloc(p1);
    send(mk_alu(OP_ADDS, ready_op(32'd5), ready_op(-32'sd5), p1), 1'b0);
    alloc(p1);
    send(mk_alu(OP_SUBS, ready_op(32'd3), ready_op(32'd7), p1), 1'b0);
    alloc(p1);
    send(mk_alu(OP_ADDS, ready_op(32'hffff_ffff), ready_op(32'd1), p1), 1'b0);
    alloc(p1);
    send(mk_alu(OP_ADDS, ready_op(32'h7fff_ffff), ready_op(32'd1), p1), 1'b0);
    alloc(p1);
    send(mk_alu(OP_SUBS, ready_op(32'h8000_0000), ready_op(32'd1), p1), 1'b0);
    idle();
    wait_drain();

    // Loads and stores
    alloc(l);
    send(mk_ls(OP_LDUR, ready_op(32'd0), ready_op(32'd0), 12'd40, l), 1'b0);
    alloc(s);
    send(mk_ls(OP_STUR, ready_op(32'd0), ready_op($random(seed)), 12'd5, s), 1'b0);
    alloc(l);
    send(mk_ls(OP_LDUR, ready_op(32'd3), ready_op(32'd0), 12'd2, l), 1'b0);
    r1  = $random(seed);
    imm = 12'($random(seed));
    alloc(s);
    send(mk_ls(OP_STUR, ready_op(r1), ready_op($random(seed)), imm, s), 1'b0);
    alloc(l);
    send(mk_ls(OP_LDUR, ready_op(r1), ready_op(32'd0), imm, l), 1'b0);
    idle();
    wait_drain();

    // LS station fills behind a late tag while the ALU keeps going
    alloc(late);
    alloc(x);
    record_expect(mk_alu(OP_ADD, ready_op(32'd17), ready_op(32'd4), late));
    send(mk_alu(OP_ORR, wait_op(late), ready_op(32'd0), x), 1'b0);
    repeat (4) begin
      alloc(l);
      send(mk_ls(OP_LDUR, wait_op(x), ready_op(32'd0), 12'($random(seed)), l), 1'b0);
    end
    idle();
    check_full(1'b1);
    alloc(p1);
    send(mk_alu(OP_EOR, ready_op($random(seed)), ready_op($random(seed)), p1), 1'b1);
    idle();
    wait_tag(p1);
    check_full(1'b1);
    send(mk_alu(OP_ADD, ready_op(32'd17), ready_op(32'd4), late), 1'b0);
    idle();
    wait_drain();

    // ALU station fills behind a load that is dispatched last
    alloc(l);
    record_expect(mk_ls(OP_LDUR, ready_op(32'd3), ready_op(32'd0), 12'd2, l));
    repeat (4) begin
      alloc(p1);
      send(mk_alu(OP_ADD, wait_op(l), ready_op($random(seed)), p1), 1'b0);
    end
    idle();
    check_full(1'b0);
    send(mk_ls(OP_LDUR, ready_op(32'd3), ready_op(32'd0), 12'd2, l), 1'b0);
    idle();
    wait_drain();

    // Both units finish together on one shared wakeup
    repeat (6) begin
      alloc(p1);
      alloc(p2);
      alloc(l);
      send(mk_alu(OP_ADD, ready_op($random(seed)), ready_op($random(seed)), p1), 1'b0);
      send(mk_alu(OP_EOR, wait_op(p1), ready_op($random(seed)), p2), 1'b0);
      send(mk_ls(OP_LDUR, wait_op(p1), ready_op(32'd0), 12'($random(seed)), l), 1'b0);
      idle();
    end
    wait_drain();

    $display("NO ERRORS");
    $finish;
  end

endmodule

`default_nettype wire

// ==== issue_core.f ====
logic/issue_pkg.sv
logic/rs_station.sv
logic/alu_unit.sv
logic/ls_unit.sv
logic/cdb_arbiter.sv
logic/issue_core.sv
tb/tb_clock.sv
tb/issue_core_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the issue stage testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert --top-module issue_core_tb -f issue_core.f \
  -o issue_core_sim > sim.log 2>&1 \
  && ./obj_dir/issue_core_sim >> sim.log 2>&1

cat sim.log
grep -q "ERRORS FOUND" sim.log && { echo "Simulation failed"; exit 1; } \
  || grep -q "NO ERRORS" sim.log || { echo "Simulation did not complete"; exit 1; }
echo "Simulation passed"
